/* hw/l2k_isa_pkg.sv */
/*
 * Limn2600 integer ISA definitions
 * Instruction field encodings, opcode classes, ALU, branch,
 * shift and transfer size codes used by the core
 */

`default_nettype none

package l2k_isa_pkg;

    typedef logic [31:0] word_t;   // Data word or byte address
    typedef logic [4:0]  regno_t;  // General register number

    // Register group reuses code 0 as NOR
    typedef enum logic [2:0] {
        ALU_LUI  = 3'd0,
        ALU_OR   = 3'd1,
        ALU_XOR  = 3'd2,
        ALU_AND  = 3'd3,
        ALU_SLTS = 3'd4,  // Signed compare
        ALU_SLT  = 3'd5,  // Unsigned compare
        ALU_SUB  = 3'd6,
        ALU_ADD  = 3'd7
    } alu_op_t;

    // Condition is tested on ra alone
    typedef enum logic [2:0] {
        BR_ODD  = 3'd0,
        BR_EVEN = 3'd1,
        BR_LE   = 3'd2,
        BR_GE   = 3'd3,
        BR_GT   = 3'd4,
        BR_LT   = 3'd5,
        BR_NEZ  = 3'd6,
        BR_EQZ  = 3'd7
    } br_cond_t;

    typedef enum logic [1:0] {
        SH_LEFT  = 2'd0,
        SH_RIGHT = 2'd1,
        SH_ARITH = 2'd2,
        SH_ROR   = 2'd3
    } shift_mode_t;

    typedef logic [1:0] mem_size_t;  // Inverse of the transfer size field

    ////////////////////
    // Opcode classes, matched on inst[5:0]
    localparam logic [2:0] OPC_IMM_ALU = 3'b100;     // inst[2:0]
    localparam logic [2:0] OPC_BRANCH  = 3'b101;     // inst[2:0]
    localparam logic [1:0] OPC_JAL     = 2'b11;      // inst[2:1], bit 0 is link
    localparam logic [2:0] OPC_STORE   = 3'b010;     // inst[2:0]
    localparam logic [5:0] OPC_JALR    = 6'b111000;
    localparam logic [5:0] OPC_REG_ALU = 6'b111001;
    localparam logic [5:0] OPC_PRIV    = 6'b101001;
    localparam logic [3:0] GRP_HLT     = 4'b1100;    // inst[31:28] in privileged group

    localparam regno_t REG_LR = 5'd31;  // Link target of JAL

endpackage

`default_nettype wire

/* hw/l2k_uop_pkg.sv */
/*
 * Micro-operation types
 * What decode hands to execute once the opcode is classified
 */

`default_nettype none

package l2k_uop_pkg;

    typedef enum logic [2:0] {
        UOP_NONE,    // Bubble or unsupported opcode
        UOP_ALU,     // Immediate or register ALU, LUI
        UOP_NOR,
        UOP_BRANCH,
        UOP_JAL,
        UOP_JALR,
        UOP_STORE,
        UOP_HALT
    } uop_kind_t;

    // Second ALU operand source
    typedef enum logic {
        SRC_IMM,
        SRC_SHIFTED_REG
    } src_b_t;

endpackage

`default_nettype wire

/* hw/l2k_fetch.sv */
/*
 * Fetch stage
 * Holds the program counter and drives the synchronous instruction
 * port, tracking validity of the fetch in flight across redirects
 * and halt
 */

`timescale 1ns/1ps
`default_nettype none

module l2k_fetch #(
    parameter l2k_isa_pkg::word_t RESET_PC = 32'hFFFE_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               redirect,
    input  l2k_isa_pkg::word_t redirect_pc,
    input  logic               halt_req,
    output l2k_isa_pkg::word_t imem_addr,
    output logic               inst_valid,
    output l2k_isa_pkg::word_t inst_pc,
    output logic               halted
);
    import l2k_isa_pkg::*;

    word_t pc;

    assign imem_addr = pc;  // Data returns next cycle

    always_ff @(posedge clk) begin
        if (rst) begin
            pc         <= RESET_PC;
            inst_valid <= 1'b0;
            halted     <= 1'b0;
        end else begin
            // Arriving word is dropped when execute takes a jump or halts
            inst_valid <= !halted && !redirect && !halt_req;
            if (halt_req) begin
                halted <= 1'b1;
            end
            if (redirect) begin
                pc <= redirect_pc;
            end else if (!halted && !halt_req) begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        inst_pc <= pc;  // Address of the word in flight
    end

    // Execute never jumps and halts in the same cycle
    a_redirect_halt_excl: assert property (@(posedge clk) disable iff (rst)
        !(redirect && halt_req));

endmodule

`default_nettype wire

/* hw/l2k_regfile.sv */
/*
 * General register file
 * 32 registers, three combinational reads, one write,
 * r0 always reads zero
 */

`timescale 1ns/1ps
`default_nettype none

module l2k_regfile (
    input  logic                clk,
    input  logic                rst,
    input  l2k_isa_pkg::regno_t rd_addr_a,
    input  l2k_isa_pkg::regno_t rd_addr_b,
    input  l2k_isa_pkg::regno_t rd_addr_c,
    input  logic                wb_enable,
    input  l2k_isa_pkg::regno_t wb_reg,
    input  l2k_isa_pkg::word_t  wb_value,
    output l2k_isa_pkg::word_t  rd_data_a,
    output l2k_isa_pkg::word_t  rd_data_b,
    output l2k_isa_pkg::word_t  rd_data_c
);
    import l2k_isa_pkg::*;

    word_t regs [32];

    assign rd_data_a = (rd_addr_a == '0) ? '0 : regs[rd_addr_a];
    assign rd_data_b = (rd_addr_b == '0) ? '0 : regs[rd_addr_b];
    assign rd_data_c = (rd_addr_c == '0) ? '0 : regs[rd_addr_c];  // ra of stores and branches

    always_ff @(posedge clk) begin
        if (wb_enable) begin
            regs[wb_reg] <= wb_value;
        end
    end

    // Execute filters r0 targets before they reach the write port
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        wb_enable |-> wb_reg != '0);

endmodule

`default_nettype wire

/* hw/l2k_decode.sv */
/*
 * Decode stage
 * Splits the instruction fields, classifies the opcode, reads and
 * forwards register operands, prepares immediates and registers
 * the micro-operation into execute
 */

`timescale 1ns/1ps
`default_nettype none

module l2k_decode (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid,
    input  l2k_isa_pkg::word_t       inst_pc,
    input  l2k_isa_pkg::word_t       imem_data,
    input  logic                     redirect,
    input  logic                     halt_req,
    input  l2k_isa_pkg::word_t       rd_data_a,
    input  l2k_isa_pkg::word_t       rd_data_b,
    input  l2k_isa_pkg::word_t       rd_data_c,
    input  logic                     wb_enable,
    input  l2k_isa_pkg::regno_t      wb_reg,
    input  l2k_isa_pkg::word_t       wb_value,
    output l2k_isa_pkg::regno_t      rd_addr_a,
    output l2k_isa_pkg::regno_t      rd_addr_b,
    output l2k_isa_pkg::regno_t      rd_addr_c,
    output logic                     uop_valid,
    output l2k_uop_pkg::uop_kind_t   uop_kind,
    output l2k_isa_pkg::alu_op_t     alu_op,
    output l2k_uop_pkg::src_b_t      src_b,
    output l2k_isa_pkg::br_cond_t    br_cond,
    output l2k_isa_pkg::shift_mode_t shift_mode,
    output logic [4:0]               shift_amount,
    output l2k_isa_pkg::word_t       op_a,
    output l2k_isa_pkg::word_t       op_b,
    output l2k_isa_pkg::word_t       op_c,
    output l2k_isa_pkg::word_t       imm,
    output l2k_isa_pkg::regno_t      rd,
    output logic                     rd_link,
    output l2k_isa_pkg::mem_size_t   store_size,
    output l2k_isa_pkg::word_t       uop_pc
);
    import l2k_isa_pkg::*;
    import l2k_uop_pkg::*;

    ////////////////////
    // Instruction fields
    logic [5:0]  inst_lo;
    logic [5:0]  inst_hi;
    logic [4:0]  imm5;
    logic [4:0]  imm5_lo;    // Shift amount of the register group
    logic [15:0] imm16;
    logic [20:0] imm21;
    logic [28:0] imm29;
    regno_t      opreg1;
    regno_t      opreg2;
    regno_t      opreg3;
    logic [1:0]  shift_fld;
    logic [1:0]  tsz;        // Transfer size of stores

    assign inst_lo   = imem_data[5:0];
    assign inst_hi   = imem_data[31:26];
    assign imm5      = imem_data[15:11];
    assign imm5_lo   = imem_data[25:21];
    assign imm16     = imem_data[31:16];
    assign imm21     = imem_data[31:11];
    assign imm29     = imem_data[31:3];
    assign opreg1    = imem_data[10:6];
    assign opreg2    = imem_data[15:11];
    assign opreg3    = imem_data[20:16];
    assign shift_fld = imem_data[27:26];
    assign tsz       = imem_data[4:3];

    assign rd_addr_a = opreg2;
    assign rd_addr_b = opreg3;
    assign rd_addr_c = opreg1;

    ////////////////////
    // Operands with writeback forwarding
    word_t fwd_a;
    word_t fwd_b;
    word_t fwd_c;

    assign fwd_a = (wb_enable && wb_reg == opreg2) ? wb_value : rd_data_a;
    assign fwd_b = (wb_enable && wb_reg == opreg3) ? wb_value : rd_data_b;
    assign fwd_c = (wb_enable && wb_reg == opreg1) ? wb_value : rd_data_c;

    uop_kind_t kind_d;
    alu_op_t   alu_op_d;
    src_b_t    src_b_d;
    regno_t    rd_d;
    logic      rd_link_d;
    word_t     imm_d;
    word_t     op_b_d;

    always_comb begin
        kind_d    = UOP_NONE;
        alu_op_d  = alu_op_t'(inst_lo[5:3]);
        src_b_d   = SRC_IMM;
        rd_d      = opreg1;
        rd_link_d = 1'b0;
        imm_d     = {16'b0, imm16};  // ALU immediate is zero extended
        op_b_d    = fwd_b;
        if (inst_lo == OPC_JALR) begin
            kind_d    = UOP_JALR;
            rd_link_d = 1'b1;
            imm_d     = {{14{imm16[15]}}, imm16, 2'b00};
        end else if (inst_lo == OPC_REG_ALU) begin
            src_b_d  = SRC_SHIFTED_REG;
            alu_op_d = alu_op_t'(inst_hi[4:2]);
            if (inst_hi[5:2] == 4'b0000) begin
                kind_d = UOP_NOR;
            end else if (!inst_hi[5]) begin
                kind_d = UOP_ALU;        // Upper half holds memory forms
            end
        end else if (inst_lo == OPC_PRIV) begin
            if (inst_hi[5:2] == GRP_HLT) begin
                kind_d = UOP_HALT;
            end
        end else if (inst_lo[2:1] == OPC_JAL) begin
            kind_d    = UOP_JAL;
            rd_d      = REG_LR;
            rd_link_d = inst_lo[0];
            imm_d     = {1'b0, imm29, 2'b00};
        end else if (inst_lo[2:0] == OPC_BRANCH) begin
            kind_d = UOP_BRANCH;
            imm_d  = {{9{imm21[20]}}, imm21, 2'b00};
        end else if (inst_lo[2:0] == OPC_IMM_ALU) begin
            kind_d = UOP_ALU;
        end else if (inst_lo[2:0] == OPC_STORE) begin
            kind_d = UOP_STORE;
            imm_d  = {16'b0, imm16} << ~tsz;
            op_b_d = inst_lo[5] ? fwd_a : {27'b0, imm5};  // Store data
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            uop_valid <= 1'b0;
        end else begin
            uop_valid <= inst_valid && !redirect && !halt_req;  // Killed by jump or halt
        end
    end

    always_ff @(posedge clk) begin
        uop_kind     <= kind_d;
        alu_op       <= alu_op_d;
        src_b        <= src_b_d;
        br_cond      <= br_cond_t'(inst_lo[5:3]);
        shift_mode   <= shift_mode_t'(shift_fld);
        shift_amount <= imm5_lo;
        op_a         <= fwd_a;
        op_b         <= op_b_d;
        op_c         <= fwd_c;
        imm          <= imm_d;
        rd           <= rd_d;
        rd_link      <= rd_link_d;
        store_size   <= ~tsz;
        uop_pc       <= inst_pc;
    end

    // Program holds only the supported opcode set
    a_known_opcode: assert property (@(posedge clk) disable iff (rst)
        (inst_valid && !redirect && !halt_req) |-> kind_d != UOP_NONE);

endmodule

`default_nettype wire

/* hw/l2k_execute.sv */
/*
 * Execute stage
 * ALU, shifter and branch compare, jump targets, register writeback
 * and the registered store port
 */

`timescale 1ns/1ps
`default_nettype none

module l2k_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     uop_valid,
    input  l2k_uop_pkg::uop_kind_t   uop_kind,
    input  l2k_isa_pkg::alu_op_t     alu_op,
    input  l2k_uop_pkg::src_b_t      src_b,
    input  l2k_isa_pkg::br_cond_t    br_cond,
    input  l2k_isa_pkg::shift_mode_t shift_mode,
    input  logic [4:0]               shift_amount,
    input  l2k_isa_pkg::word_t       op_a,
    input  l2k_isa_pkg::word_t       op_b,
    input  l2k_isa_pkg::word_t       op_c,
    input  l2k_isa_pkg::word_t       imm,
    input  l2k_isa_pkg::regno_t      rd,
    input  logic                     rd_link,
    input  l2k_isa_pkg::mem_size_t   store_size,
    input  l2k_isa_pkg::word_t       uop_pc,
    output logic                     wb_enable,
    output l2k_isa_pkg::regno_t      wb_reg,
    output l2k_isa_pkg::word_t       wb_value,
    output logic                     redirect,
    output l2k_isa_pkg::word_t       redirect_pc,
    output logic                     halt_req,
    output logic                     write_enable,
    output l2k_isa_pkg::word_t       write_addr,
    output l2k_isa_pkg::word_t       write_value,
    output l2k_isa_pkg::mem_size_t   write_size
);
    import l2k_isa_pkg::*;
    import l2k_uop_pkg::*;

    function automatic word_t shift_op(word_t v, logic [4:0] n, shift_mode_t m);
        logic [63:0] rot;
        rot = {v, v} >> n;
        case (m)
            SH_LEFT:  return v << n;
            SH_RIGHT: return v >> n;
            SH_ARITH: return word_t'($signed(v) >>> n);
            default:  return rot[31:0];  // Rotate right
        endcase
    endfunction

    function automatic word_t alu(alu_op_t op, word_t a, word_t b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLT:  return {31'b0, a < b};
            ALU_SLTS: return {31'b0, $signed(a) < $signed(b)};
            ALU_AND:  return a & b;
            ALU_XOR:  return a ^ b;
            ALU_OR:   return a | b;
            default:  return a | (b << 16);  // LUI
        endcase
    endfunction

    function automatic logic br_taken(br_cond_t c, word_t a);
        case (c)
            BR_EQZ:  return a == '0;
            BR_NEZ:  return a != '0;
            BR_LT:   return $signed(a) < 0;
            BR_GT:   return $signed(a) > 0;
            BR_GE:   return $signed(a) >= 0;
            BR_LE:   return $signed(a) <= 0;
            BR_EVEN: return !a[0];
            default: return a[0];
        endcase
    endfunction

    word_t shifted;
    word_t alu_b;
    logic  is_jump;
    logic  writes;

    assign shifted = shift_op(op_b, shift_amount, shift_mode);
    assign alu_b   = (src_b == SRC_IMM) ? imm : shifted;

    ////////////////////
    // Writeback at the edge closing this cycle
    assign is_jump = uop_kind == UOP_JAL || uop_kind == UOP_JALR;
    assign writes  = uop_kind == UOP_ALU || uop_kind == UOP_NOR || (is_jump && rd_link);

    assign wb_enable = uop_valid && writes && rd != '0;  // r0 writes discarded
    assign wb_reg    = rd;

    always_comb begin
        case (uop_kind)
            UOP_NOR: wb_value = ~(op_a | shifted);
            UOP_JAL, UOP_JALR: wb_value = uop_pc + 32'd4;
            default: wb_value = alu(alu_op, op_a, alu_b);
        endcase
    end

    ////////////////////
    // Control flow
    always_comb begin
        case (uop_kind)
            UOP_JAL:  redirect_pc = {uop_pc[31], 31'b0} | imm;  // Stays in the same half
            UOP_JALR: redirect_pc = op_a + imm;
            default:  redirect_pc = uop_pc + imm;
        endcase
    end

    assign redirect = uop_valid && (is_jump || (uop_kind == UOP_BRANCH && br_taken(br_cond, op_c)));
    assign halt_req = uop_valid && uop_kind == UOP_HALT;

    ////////////////////
    // Store port
    always_ff @(posedge clk) begin
        if (rst) begin
            write_enable <= 1'b0;
        end else begin
            write_enable <= uop_valid && uop_kind == UOP_STORE;
        end
    end

    always_ff @(posedge clk) begin
        write_addr  <= op_c + imm;  // Offset already scaled by size
        write_value <= op_b;
        write_size  <= store_size;
    end

    // Back-to-back pulses come from two different stores
    a_store_pulse: assert property (@(posedge clk) disable iff (rst)
        (write_enable && $past(write_enable)) |-> $past(uop_pc) != $past(uop_pc, 2));

endmodule

`default_nettype wire

/* hw/l2k_core.sv */
/*
 * Limn2600 integer core top level
 * Three stage pipeline of fetch, decode and execute around the
 * register file
 */

`timescale 1ns/1ps
`default_nettype none

module l2k_core #(
    parameter l2k_isa_pkg::word_t RESET_PC = 32'hFFFE_0000
) (
    input  logic                   clk,
    input  logic                   rst,
    input  l2k_isa_pkg::word_t     imem_data,
    output l2k_isa_pkg::word_t     imem_addr,
    output logic                   write_enable,
    output l2k_isa_pkg::word_t     write_addr,
    output l2k_isa_pkg::word_t     write_value,
    output l2k_isa_pkg::mem_size_t write_size,
    output logic                   halted
);
    import l2k_isa_pkg::*;
    import l2k_uop_pkg::*;

    logic        inst_valid;
    word_t       inst_pc;
    regno_t      rd_addr_a;
    regno_t      rd_addr_b;
    regno_t      rd_addr_c;
    word_t       rd_data_a;
    word_t       rd_data_b;
    word_t       rd_data_c;
    logic        uop_valid;
    uop_kind_t   uop_kind;
    alu_op_t     alu_op;
    src_b_t      src_b;
    br_cond_t    br_cond;
    shift_mode_t shift_mode;
    logic [4:0]  shift_amount;
    word_t       op_a;
    word_t       op_b;
    word_t       op_c;
    word_t       imm;
    regno_t      rd;
    logic        rd_link;
    mem_size_t   store_size;
    word_t       uop_pc;
    logic        wb_enable;
    regno_t      wb_reg;
    word_t       wb_value;
    logic        redirect;
    word_t       redirect_pc;
    logic        halt_req;

    l2k_fetch #(.RESET_PC(RESET_PC)) fetch_i (
        .clk, .rst, .redirect, .redirect_pc, .halt_req,
        .imem_addr, .inst_valid, .inst_pc, .halted
    );

    l2k_decode decode_i (
        .clk, .rst, .inst_valid, .inst_pc, .imem_data, .redirect, .halt_req,
        .rd_data_a, .rd_data_b, .rd_data_c, .wb_enable, .wb_reg, .wb_value,
        .rd_addr_a, .rd_addr_b, .rd_addr_c,
        .uop_valid, .uop_kind, .alu_op, .src_b, .br_cond, .shift_mode, .shift_amount,
        .op_a, .op_b, .op_c, .imm, .rd, .rd_link, .store_size, .uop_pc
    );

    l2k_regfile regfile_i (
        .clk, .rst, .rd_addr_a, .rd_addr_b, .rd_addr_c,
        .wb_enable, .wb_reg, .wb_value,
        .rd_data_a, .rd_data_b, .rd_data_c
    );

    l2k_execute execute_i (
        .clk, .rst,
        .uop_valid, .uop_kind, .alu_op, .src_b, .br_cond, .shift_mode, .shift_amount,
        .op_a, .op_b, .op_c, .imm, .rd, .rd_link, .store_size, .uop_pc,
        .wb_enable, .wb_reg, .wb_value, .redirect, .redirect_pc, .halt_req,
        .write_enable, .write_addr, .write_value, .write_size
    );

endmodule

`default_nettype wire

/* sim/tb_l2k_program.svh */
/*
 * Test program for the integer core
 * Instruction encoders, the program image and the list of stores
 * it must produce, worked out from the instruction set rules
 */

`ifndef TB_L2K_PROGRAM_SVH
`define TB_L2K_PROGRAM_SVH

localparam logic [1:0] TSZ_W = 2'b01;  // Port size 10
localparam logic [1:0] TSZ_H = 2'b10;  // Port size 01
localparam logic [1:0] TSZ_B = 2'b11;  // Port size 00
localparam logic [31:0] HLT_INST = 32'hC000_0029;

function automatic logic [31:0] imm_alu_inst(logic [2:0] op, logic [4:0] rd,
                                             logic [4:0] ra, logic [15:0] v);
    return {v, ra, rd, op, 3'b100};
endfunction

function automatic logic [31:0] reg_alu_inst(logic [2:0] op, logic [1:0] mode,
        logic [4:0] amt, logic [4:0] rd, logic [4:0] ra, logic [4:0] rb);
    return {1'b0, op, mode, amt, rb, ra, rd, 6'b111001};  // Op 0 is NOR
endfunction

function automatic logic [31:0] branch_inst(logic [2:0] cond, logic [4:0] ra, int off);
    logic [20:0] o;
    o = off[20:0];  // Offset in words from the branch
    return {o, ra, cond, 3'b101};
endfunction

function automatic logic [31:0] jal_inst(logic link, logic [31:0] target);
    return {target[30:2], 2'b11, link};
endfunction

function automatic logic [31:0] jalr_inst(logic [4:0] rd, logic [4:0] ra, logic [15:0] off);
    return {off, ra, rd, 6'b111000};
endfunction

function automatic logic [31:0] reg_store_inst(logic [1:0] tsz, logic [4:0] base,
                                               logic [4:0] src, logic [15:0] off);
    return {off, src, base, 1'b1, tsz, 3'b010};
endfunction

function automatic logic [31:0] imm_store_inst(logic [1:0] tsz, logic [4:0] base,
                                               logic [4:0] v, logic [15:0] off);
    return {off, v, base, 1'b0, tsz, 3'b010};
endfunction

function automatic logic [31:0] inst_addr(int k);
    return RESET_PC + 32'(4 * k);
endfunction

task automatic emit(input logic [31:0] w);
    rom[prog_len] = w;
    prog_len++;
endtask

task automatic expect_store(input logic [31:0] a, input logic [31:0] v, input logic [1:0] s);
    exp_addr.push_back(a);
    exp_value.push_back(v);
    exp_size.push_back(s);
endtask

// Word store from r0 base, slot scaled by 4
task automatic store_word(input logic [4:0] src, input logic [15:0] slot,
                          input logic [31:0] v);
    emit(reg_store_inst(TSZ_W, 5'd0, src, slot));
    expect_store({14'b0, slot, 2'b00}, v, 2'b10);
endtask

// Marker that must never reach the port
task automatic emit_bad_store();
    emit(imm_store_inst(TSZ_B, 5'd0, 5'h1F, 16'h01FF));
endtask

// Taken branch over two bad stores, then a not-taken one before a marker
task automatic branch_pair(input logic [2:0] cond, input logic [4:0] ra_taken,
                           input logic [4:0] ra_not, input logic [4:0] marker);
    emit(branch_inst(cond, ra_taken, 3));
    emit_bad_store();
    emit_bad_store();
    emit(branch_inst(cond, ra_not, 2));
    emit(imm_store_inst(TSZ_B, 5'd0, marker, {11'h008, marker}));
    expect_store({23'b0, 4'h8, marker}, {27'b0, marker}, 2'b00);
endtask

task automatic load_program();
    int k;
    int j;
    ////////////////////
    // Immediate group
    emit(imm_alu_inst(3'd7, 5'd1, 5'd0, 16'h1234));    // ADDI r1
    store_word(5'd1, 16'h0010, 32'h0000_1234);         // Back to back
    emit(imm_alu_inst(3'd6, 5'd2, 5'd1, 16'h0034));    // SUBI
    emit(imm_alu_inst(3'd5, 5'd3, 5'd2, 16'h1201));    // SLTI
    emit(imm_alu_inst(3'd0, 5'd5, 5'd0, 16'h8000));    // LUI
    emit(imm_alu_inst(3'd4, 5'd4, 5'd5, 16'h0001));    // SLTIS
    emit(imm_alu_inst(3'd5, 5'd6, 5'd5, 16'h0001));
    emit(imm_alu_inst(3'd3, 5'd7, 5'd1, 16'h0F0F));    // ANDI
    emit(imm_alu_inst(3'd2, 5'd8, 5'd1, 16'hFFFF));    // XORI
    emit(imm_alu_inst(3'd1, 5'd9, 5'd5, 16'h00A5));    // ORI
    emit(imm_alu_inst(3'd0, 5'd10, 5'd9, 16'h0001));   // LUI onto r9
    store_word(5'd2, 16'h0011, 32'h0000_1200);
    store_word(5'd3, 16'h0012, 32'h0000_0001);
    store_word(5'd4, 16'h0013, 32'h0000_0001);
    store_word(5'd6, 16'h0014, 32'h0000_0000);
    store_word(5'd7, 16'h0015, 32'h0000_0204);
    store_word(5'd8, 16'h0016, 32'h0000_EDCB);
    store_word(5'd9, 16'h0017, 32'h8000_00A5);
    store_word(5'd10, 16'h0018, 32'h8001_00A5);
    store_word(5'd1, 16'h0019, 32'h0000_1234);         // After writeback
    ////////////////////
    // Register group with shifted rb
    emit(reg_alu_inst(3'd7, 2'd0, 5'd4, 5'd11, 5'd1, 5'd1));
    emit(reg_alu_inst(3'd6, 2'd1, 5'd28, 5'd12, 5'd1, 5'd5));
    emit(reg_alu_inst(3'd1, 2'd2, 5'd4, 5'd13, 5'd0, 5'd5));
    emit(reg_alu_inst(3'd2, 2'd3, 5'd8, 5'd14, 5'd0, 5'd1));
    emit(reg_alu_inst(3'd0, 2'd0, 5'd1, 5'd15, 5'd1, 5'd1));
    store_word(5'd11, 16'h001A, 32'h0001_3574);
    store_word(5'd12, 16'h001B, 32'h0000_122C);
    store_word(5'd13, 16'h001C, 32'hF800_0000);
    store_word(5'd14, 16'h001D, 32'h3400_0012);
    store_word(5'd15, 16'h001E, 32'hFFFF_C983);
    ////////////////////
    // Branches on r0 zero, r1 even positive, r5 negative, r16 odd
    emit(imm_alu_inst(3'd7, 5'd16, 5'd0, 16'h0001));
    branch_pair(3'd7, 5'd0, 5'd1, 5'd1);
    branch_pair(3'd6, 5'd1, 5'd0, 5'd2);
    branch_pair(3'd5, 5'd5, 5'd1, 5'd3);
    branch_pair(3'd4, 5'd1, 5'd5, 5'd4);
    branch_pair(3'd3, 5'd0, 5'd5, 5'd5);
    branch_pair(3'd2, 5'd5, 5'd1, 5'd6);
    branch_pair(3'd1, 5'd1, 5'd16, 5'd7);
    branch_pair(3'd0, 5'd16, 5'd1, 5'd8);
    emit(branch_inst(3'd6, 5'd1, 3));
    emit(imm_store_inst(TSZ_B, 5'd0, 5'h1E, 16'h011E));  // Reached backward
    expect_store(32'h0000_011E, 32'h0000_001E, 2'b00);
    emit(branch_inst(3'd7, 5'd0, 3));
    emit(branch_inst(3'd7, 5'd0, -2));
    emit_bad_store();
    ////////////////////
    // Jumps
    k = prog_len;
    emit(jal_inst(1'b0, inst_addr(k + 3)));
    emit_bad_store();
    emit_bad_store();
    k = prog_len;
    emit(jal_inst(1'b1, inst_addr(k + 3)));
    emit_bad_store();
    emit_bad_store();
    store_word(5'd31, 16'h0020, inst_addr(k + 1));
    j = prog_len;
    emit(jalr_inst(5'd17, 5'd31, 16'(j - k + 2)));     // r31 holds addr of k+1
    emit_bad_store();
    emit_bad_store();
    store_word(5'd17, 16'h0021, inst_addr(j + 1));
    ////////////////////
    // Store sizes, both data forms
    emit(reg_store_inst(TSZ_B, 5'd0, 5'd1, 16'h0201));
    expect_store(32'h0000_0201, 32'h0000_1234, 2'b00);
    emit(reg_store_inst(TSZ_H, 5'd0, 5'd5, 16'h0102));
    expect_store(32'h0000_0204, 32'h8000_0000, 2'b01);
    emit(imm_store_inst(TSZ_H, 5'd0, 5'h15, 16'h0103));
    expect_store(32'h0000_0206, 32'h0000_0015, 2'b01);
    emit(imm_store_inst(TSZ_W, 5'd0, 5'h0A, 16'h0082));
    expect_store(32'h0000_0208, 32'h0000_000A, 2'b10);
    emit(reg_store_inst(TSZ_W, 5'd2, 5'd8, 16'h0003));  // Base r2
    expect_store(32'h0000_120C, 32'h0000_EDCB, 2'b10);
    ////////////////////
    // r0 write attempt, then halt
    emit(imm_alu_inst(3'd7, 5'd0, 5'd0, 16'h0055));
    store_word(5'd0, 16'h0024, 32'h0000_0000);
    emit(HLT_INST);
    emit_bad_store();
    emit_bad_store();
    emit_bad_store();
endtask

`endif

/* sim/tb_l2k_core.sv */
/*
 * Testbench for the integer core
 * Runs a program from a synchronous ROM and checks every store
 * pulse against the expected list, then checks the halt
 */

`timescale 1ns/1ps
`default_nettype none

module tb_l2k_core;

    localparam logic [31:0] RESET_PC = 32'hFFFE_0000;
    localparam int ROM_WORDS = 256;

    logic        clk = 1'b0;
    logic        rst;
    logic [31:0] imem_data;
    logic [31:0] imem_addr;
    logic        write_enable;
    logic [31:0] write_addr;
    logic [31:0] write_value;
    logic [1:0]  write_size;
    logic        halted;

    logic [31:0] rom [ROM_WORDS];
    logic [31:0] rom_off;
    logic [7:0]  fetch_idx;
    int          prog_len = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          cycles = 0;
    int          limit = 1000;
    int          seed;
    logic        halt_seen = 1'b0;
    logic [31:0] exp_addr [$];
    logic [31:0] exp_value [$];
    logic [1:0]  exp_size [$];

    `include "tb_l2k_program.svh"

    l2k_core #(.RESET_PC(RESET_PC)) dut_i (
        .clk, .rst, .imem_data, .imem_addr,
        .write_enable, .write_addr, .write_value, .write_size, .halted
    );

    always #4 clk = ~clk;  // 8 ns period

    ////////////////////
    // Synchronous instruction ROM
    assign rom_off = imem_addr - RESET_PC;

    always @(posedge clk) begin
        fetch_idx <= rom_off[9:2];
    end

    always @(negedge clk) begin
        imem_data <= rom[fetch_idx];  // Word seen by decode next cycle
    end

    task automatic compare_signal(input string name, input logic [31:0] got,
                                  input logic [31:0] expv);
        assert (got === expv) else begin
            value_errors++;
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, expv);
        end
    endtask

    task automatic check_store();
        assert (exp_addr.size() != 0) else begin
            other_errors++;
            $display("Store to %h at %0t was not expected", write_addr, $time);
        end
        if (exp_addr.size() != 0) begin
            compare_signal("write_addr", write_addr, exp_addr.pop_front());
            compare_signal("write_value", write_value, exp_value.pop_front());
            compare_signal("write_size", {30'b0, write_size}, {30'b0, exp_size.pop_front()});
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (halt_seen) begin
                assert (halted) else begin
                    other_errors++;
                    $display("halted dropped low again at %0t", $time);
                end
            end
            assert (!(halted && write_enable)) else begin
                other_errors++;
                $display("Store issued after halt at %0t", $time);
            end
            if (write_enable && !halted) begin
                check_store();
            end
            if (halted) begin
                halt_seen = 1'b1;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("Timeout after %0d cycles, core never halted", limit);
            $display("Errors: %0d value, %0d other", value_errors, other_errors + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        rst       = 1'b1;
        imem_data = 32'h0;
        seed      = 59;
        for (int i = 0; i < ROM_WORDS; i++) begin
            rnd    = $random(seed);
            rom[i] = imm_alu_inst(3'd1, 5'd0, 5'd0, rnd[15:0] ^ 16'(i));  // ORI to r0
        end
        load_program();
        limit = 2 * prog_len + 50;
        repeat (4) @(negedge clk);
        rst = 1'b0;
        while (!halted) @(negedge clk);
        repeat (10) @(negedge clk);  // Halt must hold with no stores
        assert (exp_addr.size() == 0) else begin
            other_errors++;
            $display("%0d expected stores never happened", exp_addr.size());
        end
        $display("Errors: %0d value, %0d other", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* l2k_core.f */
hw/l2k_isa_pkg.sv
hw/l2k_uop_pkg.sv
hw/l2k_fetch.sv
hw/l2k_regfile.sv
hw/l2k_decode.sv
hw/l2k_execute.sv
hw/l2k_core.sv
+incdir+sim
sim/tb_l2k_core.sv

/* Makefile */
TOP = tb_l2k_core

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f l2k_core.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir
